//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = tb_ooo_core
FILELIST  = vlog.f

OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
PASS_MSG  = Test completed successfully

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_AREGS  = 32;
    localparam int NUM_PREGS  = 48;
    localparam int FREE_DEPTH = NUM_PREGS - NUM_AREGS;  // pregs not mapped after reset
    localparam int ROB_DEPTH  = 8;
    localparam int RS_DEPTH   = 4;
    localparam int MUL_STAGES = 3;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(NUM_AREGS)-1:0] areg_t;
    typedef logic [$clog2(NUM_PREGS)-1:0] preg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

endpackage

`default_nettype wire

//--- logic/exec_units.sv
`timescale 1ns/1ps
`default_nettype none

module exec_units (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  isa_pkg::alu_op_e   issue_op,
    input  core_pkg::word_t    issue_a,
    input  core_pkg::word_t    issue_b,
    input  core_pkg::preg_t    issue_preg,
    input  core_pkg::rob_tag_t issue_tag,
    output logic               wba_valid,
    output core_pkg::preg_t    wba_preg,
    output core_pkg::rob_tag_t wba_tag,
    output core_pkg::word_t    wba_value,
    output logic               wbb_valid,
    output core_pkg::preg_t    wbb_preg,
    output core_pkg::rob_tag_t wbb_tag,
    output core_pkg::word_t    wbb_value
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t                 alu_result;
    logic [MUL_STAGES-1:0] mul_valid;
    preg_t                 mul_preg [MUL_STAGES];
    rob_tag_t              mul_tag [MUL_STAGES];
    word_t                 mul_prod [MUL_STAGES];

    always_comb begin
        case (issue_op)
            ALU_ADD: alu_result = issue_a + issue_b;
            ALU_SUB: alu_result = issue_a - issue_b;
            ALU_AND: alu_result = issue_a & issue_b;
            ALU_OR:  alu_result = issue_a | issue_b;
            ALU_XOR: alu_result = issue_a ^ issue_b;
            ALU_SLL: alu_result = issue_a << issue_b[4:0];
            ALU_SRL: alu_result = issue_a >> issue_b[4:0];
            default: alu_result = '0;  // mul goes down port b
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wba_valid <= 1'b0;
            mul_valid <= '0;
        end else begin
            wba_valid <= issue_valid && issue_op != ALU_MUL;
            mul_valid <= {mul_valid[MUL_STAGES-2:0], issue_valid && issue_op == ALU_MUL};
        end
    end

    always_ff @(posedge clk) begin
        wba_preg    <= issue_preg;
        wba_tag     <= issue_tag;
        wba_value   <= alu_result;
        mul_preg[0] <= issue_preg;
        mul_tag[0]  <= issue_tag;
        mul_prod[0] <= issue_a * issue_b;  // low half only
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_preg[s] <= mul_preg[s-1];
            mul_tag[s]  <= mul_tag[s-1];
            mul_prod[s] <= mul_prod[s-1];
        end
    end

    assign wbb_valid = mul_valid[MUL_STAGES-1];
    assign wbb_preg  = mul_preg[MUL_STAGES-1];
    assign wbb_tag   = mul_tag[MUL_STAGES-1];
    assign wbb_value = mul_prod[MUL_STAGES-1];

endmodule

`default_nettype wire

//--- logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_MUL     = 3'b000;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_MUL
    } alu_op_e;

    function automatic alu_op_e decode_op(input logic [2:0] funct3, input logic [6:0] funct7);
        alu_op_e op;
        if (funct7 == F7_MULDIV && funct3 == F3_MUL) begin
            op = ALU_MUL;
        end else begin
            case (funct3)
                F3_ADD_SUB: op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                F3_SLL:     op = ALU_SLL;
                F3_XOR:     op = ALU_XOR;
                F3_SRL:     op = ALU_SRL;
                F3_OR:      op = ALU_OR;
                F3_AND:     op = ALU_AND;
                default:    op = ALU_ADD;  // slt/sltu not supported
            endcase
        end
        return op;
    endfunction

endpackage

`default_nettype wire

//--- logic/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  core_pkg::word_t inst,
    output logic            ready,
    output logic            commit_valid,
    output core_pkg::areg_t commit_rd,
    output core_pkg::word_t commit_value
);
    import core_pkg::*;
    import isa_pkg::*;

    // rename and dispatch
    logic     dispatch_valid;
    logic     use_imm;
    alu_op_e  alu_op;
    word_t    imm;
    preg_t    src1_preg, src2_preg;
    preg_t    dst_preg, old_preg;
    areg_t    dst_areg;
    rob_tag_t dispatch_tag;

    // operand read
    word_t    src1_value, src2_value;
    logic     src1_ready, src2_ready;

    // status back to rename
    logic     rob_full, rs_full;
    rob_tag_t rob_tail;
    logic     free_valid;
    preg_t    free_preg;

    // issue
    logic     issue_valid;
    alu_op_e  issue_op;
    word_t    issue_a, issue_b;
    preg_t    issue_preg;
    rob_tag_t issue_tag;

    // writeback, a from alu and b from mul
    logic     wba_valid, wbb_valid;
    preg_t    wba_preg, wbb_preg;
    rob_tag_t wba_tag, wbb_tag;
    word_t    wba_value, wbb_value;

    rename_unit u_rename_unit (.*);

    phys_regfile u_phys_regfile (.*);

    reservation_station u_reservation_station (.*);

    exec_units u_exec_units (.*);

    reorder_buffer u_reorder_buffer (.*);

endmodule

`default_nettype wire

//--- logic/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
    input  logic            clk,
    input  logic            rst,
    input  logic            dispatch_valid,
    input  core_pkg::preg_t dst_preg,
    input  core_pkg::preg_t src1_preg,
    input  core_pkg::preg_t src2_preg,
    input  logic            wba_valid,
    input  core_pkg::preg_t wba_preg,
    input  core_pkg::word_t wba_value,
    input  logic            wbb_valid,
    input  core_pkg::preg_t wbb_preg,
    input  core_pkg::word_t wbb_value,
    output core_pkg::word_t src1_value,
    output core_pkg::word_t src2_value,
    output logic            src1_ready,
    output logic            src2_ready
);
    import core_pkg::*;

    word_t                regs [NUM_PREGS];
    logic [NUM_PREGS-1:0] ready;
    preg_t                rd_preg [2];
    word_t                rd_value [2];
    logic                 rd_ready [2];

    assign rd_preg[0] = src1_preg;
    assign rd_preg[1] = src2_preg;

    // read with same-cycle writeback bypass
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_value[p] = regs[rd_preg[p]];
            rd_ready[p] = ready[rd_preg[p]];
            if (rd_preg[p] == '0) begin
                rd_value[p] = '0;
                rd_ready[p] = 1'b1;
            end else if (wba_valid && wba_preg == rd_preg[p]) begin
                rd_value[p] = wba_value;
                rd_ready[p] = 1'b1;
            end else if (wbb_valid && wbb_preg == rd_preg[p]) begin
                rd_value[p] = wbb_value;
                rd_ready[p] = 1'b1;
            end
        end
    end

    assign src1_value = rd_value[0];
    assign src2_value = rd_value[1];
    assign src1_ready = rd_ready[0];
    assign src2_ready = rd_ready[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
            ready <= '1;
        end else begin
            if (dispatch_valid && dst_preg != '0) begin
                ready[dst_preg] <= 1'b0;  // pending until writeback
            end
            if (wba_valid && wba_preg != '0) begin
                regs[wba_preg]  <= wba_value;
                ready[wba_preg] <= 1'b1;
            end
            if (wbb_valid && wbb_preg != '0) begin
                regs[wbb_preg]  <= wbb_value;
                ready[wbb_preg] <= 1'b1;
            end
        end
    end

    a_wb_ports_distinct: assert property (@(posedge clk) disable iff (rst)
        wba_valid && wbb_valid && wba_preg != '0 |-> wba_preg != wbb_preg)
        else $error("regfile: both writeback ports hit preg %0d", wba_preg);

endmodule

`default_nettype wire

//--- logic/rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    input  core_pkg::word_t    inst,
    input  logic               rob_full,
    input  logic               rs_full,
    input  core_pkg::rob_tag_t rob_tail,
    input  logic               free_valid,
    input  core_pkg::preg_t    free_preg,
    output logic               ready,
    output logic               dispatch_valid,
    output core_pkg::preg_t    src1_preg,
    output core_pkg::preg_t    src2_preg,
    output core_pkg::preg_t    dst_preg,
    output core_pkg::preg_t    old_preg,
    output core_pkg::areg_t    dst_areg,
    output isa_pkg::alu_op_e   alu_op,
    output logic               use_imm,
    output core_pkg::word_t    imm,
    output core_pkg::rob_tag_t dispatch_tag
);
    import core_pkg::*;
    import isa_pkg::*;

    typedef logic [$clog2(FREE_DEPTH)-1:0] free_ptr_t;

    preg_t                       rat [NUM_AREGS];
    preg_t                       free_list [FREE_DEPTH];
    free_ptr_t                   free_head;
    free_ptr_t                   free_tail;
    logic [$clog2(FREE_DEPTH):0] free_count;
    areg_t                       rs1, rs2, rd;
    logic                        alloc;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    assign use_imm = (inst[6:0] == OPC_OP_IMM);
    assign imm     = {{20{inst[31]}}, inst[31:20]};
    assign alu_op  = decode_op(inst[14:12], use_imm ? F7_BASE : inst[31:25]);

    // stall on any full structure
    assign ready          = !rob_full && !rs_full && (free_count != '0);
    assign dispatch_valid = inst_valid && ready;
    assign alloc          = dispatch_valid && (rd != '0);

    assign src1_preg    = rat[rs1];
    assign src2_preg    = rat[rs2];
    assign old_preg     = rat[rd];
    assign dst_preg     = (rd == '0) ? '0 : free_list[free_head];  // x0 stays on preg 0
    assign dst_areg     = rd;
    assign dispatch_tag = rob_tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                rat[i] <= preg_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_list[i] <= preg_t'(NUM_AREGS + i);
            end
            free_head  <= '0;
            free_tail  <= '0;
            free_count <= FREE_DEPTH[$clog2(FREE_DEPTH):0];
        end else begin
            if (alloc) begin
                rat[rd]   <= free_list[free_head];
                free_head <= free_head + 1'b1;
            end
            if (free_valid) begin
                free_list[free_tail] <= free_preg;
                free_tail            <= free_tail + 1'b1;
            end
            if (alloc && !free_valid) begin
                free_count <= free_count - 1'b1;
            end else if (free_valid && !alloc) begin
                free_count <= free_count + 1'b1;
            end
        end
    end

    a_no_accept_stalled: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> ready)
        else $error("rename: instruction offered while ready is low");

    // a returned preg must always find a slot
    a_free_no_overflow: assert property (@(posedge clk) disable iff (rst)
        free_valid && !alloc |-> free_count < FREE_DEPTH)
        else $error("rename: free list overflow");

endmodule

`default_nettype wire

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  core_pkg::areg_t    dst_areg,
    input  core_pkg::preg_t    dst_preg,
    input  core_pkg::preg_t    old_preg,
    input  logic               wba_valid,
    input  core_pkg::preg_t    wba_preg,
    input  core_pkg::rob_tag_t wba_tag,
    input  core_pkg::word_t    wba_value,
    input  logic               wbb_valid,
    input  core_pkg::preg_t    wbb_preg,
    input  core_pkg::rob_tag_t wbb_tag,
    input  core_pkg::word_t    wbb_value,
    output logic               rob_full,
    output core_pkg::rob_tag_t rob_tail,
    output logic               free_valid,
    output core_pkg::preg_t    free_preg,
    output logic               commit_valid,
    output core_pkg::areg_t    commit_rd,
    output core_pkg::word_t    commit_value
);
    import core_pkg::*;

    logic [ROB_DEPTH-1:0] valid, done;
    areg_t                areg [ROB_DEPTH];
    preg_t                preg [ROB_DEPTH];
    preg_t                prev [ROB_DEPTH];
    word_t                value [ROB_DEPTH];
    rob_tag_t             head, tail;

    assign rob_full = valid[tail];  // tail has wrapped onto head
    assign rob_tail = tail;

    assign commit_valid = valid[head] && done[head];
    assign commit_rd    = areg[head];
    assign commit_value = (areg[head] == '0) ? '0 : value[head];
    assign free_valid   = commit_valid && areg[head] != '0;
    assign free_preg    = prev[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
        end else begin
            if (dispatch_valid) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= tail + 1'b1;
            end
            if (wba_valid) begin
                done[wba_tag] <= 1'b1;
            end
            if (wbb_valid) begin
                done[wbb_tag] <= 1'b1;
            end
            if (commit_valid) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            areg[tail] <= dst_areg;
            preg[tail] <= dst_preg;
            prev[tail] <= old_preg;
        end
        if (wba_valid) begin
            value[wba_tag] <= wba_value;
        end
        if (wbb_valid) begin
            value[wbb_tag] <= wbb_value;
        end
    end

    // tag must point at a live entry renamed to the same preg
    a_wba_live: assert property (@(posedge clk) disable iff (rst)
        wba_valid |-> valid[wba_tag] && preg[wba_tag] == wba_preg)
        else $error("rob: port A writeback to empty entry %0d", wba_tag);

    a_wbb_live: assert property (@(posedge clk) disable iff (rst)
        wbb_valid |-> valid[wbb_tag] && preg[wbb_tag] == wbb_preg)
        else $error("rob: port B writeback to empty entry %0d", wbb_tag);

endmodule

`default_nettype wire

//--- logic/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  isa_pkg::alu_op_e   alu_op,
    input  core_pkg::preg_t    src1_preg,
    input  core_pkg::preg_t    src2_preg,
    input  core_pkg::word_t    src1_value,
    input  core_pkg::word_t    src2_value,
    input  logic               src1_ready,
    input  logic               src2_ready,
    input  logic               use_imm,
    input  core_pkg::word_t    imm,
    input  core_pkg::preg_t    dst_preg,
    input  core_pkg::rob_tag_t dispatch_tag,
    input  logic               wba_valid,
    input  core_pkg::preg_t    wba_preg,
    input  core_pkg::word_t    wba_value,
    input  logic               wbb_valid,
    input  core_pkg::preg_t    wbb_preg,
    input  core_pkg::word_t    wbb_value,
    output logic               rs_full,
    output logic               issue_valid,
    output isa_pkg::alu_op_e   issue_op,
    output core_pkg::word_t    issue_a,
    output core_pkg::word_t    issue_b,
    output core_pkg::preg_t    issue_preg,
    output core_pkg::rob_tag_t issue_tag
);
    import core_pkg::*;
    import isa_pkg::*;

    typedef logic [$clog2(RS_DEPTH)-1:0] rs_idx_t;

    logic [RS_DEPTH-1:0] valid;
    logic [RS_DEPTH-1:0] rdy1, rdy2;
    rs_idx_t             age [RS_DEPTH];  // count of younger entries held
    alu_op_e             op [RS_DEPTH];
    preg_t               tag1 [RS_DEPTH];
    preg_t               tag2 [RS_DEPTH];
    word_t               val1 [RS_DEPTH];
    word_t               val2 [RS_DEPTH];
    preg_t               dst [RS_DEPTH];
    rob_tag_t            rob_tag [RS_DEPTH];
    rs_idx_t             issue_idx;
    rs_idx_t             free_idx;

    assign rs_full = &valid;

    // oldest entry with both operands in
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid[i] && rdy1[i] && rdy2[i] && (!issue_valid || age[i] > age[issue_idx])) begin
                issue_valid = 1'b1;
                issue_idx   = rs_idx_t'(i);
            end
        end
    end

    always_comb begin
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = rs_idx_t'(i);
            end
        end
    end

    assign issue_op   = op[issue_idx];
    assign issue_a    = val1[issue_idx];
    assign issue_b    = val2[issue_idx];
    assign issue_preg = dst[issue_idx];
    assign issue_tag  = rob_tag[issue_idx];

    always_ff @(posedge clk) begin
        logic older_gone;
        if (rst) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                older_gone = issue_valid && age[i] > age[issue_idx];
                if (dispatch_valid && !older_gone) begin
                    age[i] <= age[i] + 1'b1;
                end else if (!dispatch_valid && older_gone) begin
                    age[i] <= age[i] - 1'b1;
                end
                // wakeup from either writeback port
                if (valid[i] && !rdy1[i]) begin
                    if (wba_valid && wba_preg == tag1[i]) begin
                        rdy1[i] <= 1'b1;
                        val1[i] <= wba_value;
                    end else if (wbb_valid && wbb_preg == tag1[i]) begin
                        rdy1[i] <= 1'b1;
                        val1[i] <= wbb_value;
                    end
                end
                if (valid[i] && !rdy2[i]) begin
                    if (wba_valid && wba_preg == tag2[i]) begin
                        rdy2[i] <= 1'b1;
                        val2[i] <= wba_value;
                    end else if (wbb_valid && wbb_preg == tag2[i]) begin
                        rdy2[i] <= 1'b1;
                        val2[i] <= wbb_value;
                    end
                end
            end
            if (issue_valid) begin
                valid[issue_idx] <= 1'b0;
            end
            if (dispatch_valid) begin
                valid[free_idx]   <= 1'b1;
                age[free_idx]     <= '0;
                op[free_idx]      <= alu_op;
                tag1[free_idx]    <= src1_preg;
                tag2[free_idx]    <= src2_preg;
                rdy1[free_idx]    <= src1_ready;
                val1[free_idx]    <= src1_value;
                rdy2[free_idx]    <= use_imm || src2_ready;  // imm is always ready
                val2[free_idx]    <= use_imm ? imm : src2_value;
                dst[free_idx]     <= dst_preg;
                rob_tag[free_idx] <= dispatch_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;
    import core_pkg::*;

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    // {funct7, funct3}
    localparam logic [9:0] OP_ADD = {7'b0000000, 3'b000};
    localparam logic [9:0] OP_SUB = {7'b0100000, 3'b000};
    localparam logic [9:0] OP_SLL = {7'b0000000, 3'b001};
    localparam logic [9:0] OP_XOR = {7'b0000000, 3'b100};
    localparam logic [9:0] OP_SRL = {7'b0000000, 3'b101};
    localparam logic [9:0] OP_OR  = {7'b0000000, 3'b110};
    localparam logic [9:0] OP_AND = {7'b0000000, 3'b111};
    localparam logic [9:0] OP_MUL = {7'b0000001, 3'b000};
    localparam int EXP_DEPTH = 1024;
    localparam int N_RANDOM  = 300;

    logic  clk = 1'b0;
    logic  rst;
    logic  inst_valid;
    word_t inst;
    logic  ready;
    logic  commit_valid;
    areg_t commit_rd;
    word_t commit_value;

    integer seed;
    string  test_name;
    word_t  arch_regs [NUM_AREGS];     // reference register state
    areg_t  exp_rd_mem [EXP_DEPTH];    // expected commits, ring indexed by count
    word_t  exp_value_mem [EXP_DEPTH];
    areg_t  exp_head_rd;
    word_t  exp_head_value;
    int     sent_count = 0;
    int     accept_count = 0;
    int     commit_count = 0;
    int     rd_errors = 0;
    int     value_errors = 0;
    int     proto_errors = 0;

    ooo_core_top ooo_core_top_i (.*);

    always #4 clk = ~clk;

    assign exp_head_rd    = exp_rd_mem[commit_count[9:0]];
    assign exp_head_value = exp_value_mem[commit_count[9:0]];

    always @(posedge clk) begin
        if (rst) begin
            accept_count <= 0;
            commit_count <= 0;
        end else begin
            if (inst_valid && ready) accept_count <= accept_count + 1;
            if (commit_valid) commit_count <= commit_count + 1;
        end
    end

    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> ready)
        else begin
            proto_errors++;
            $display("ready is low in the first cycle after reset");
        end

    a_commit_outstanding: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> accept_count > commit_count)
        else begin
            proto_errors++;
            $display("commit seen with no accepted instruction left to retire");
        end

    a_commit_rd: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_rd == exp_head_rd)
        else begin
            rd_errors++;
            $display("ERR %s rd expected %0d actual %0d", test_name,
                     $sampled(exp_head_rd), $sampled(commit_rd));
        end

    a_commit_value: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_value == exp_head_value)
        else begin
            value_errors++;
            $display("ERR %s value expected %h actual %h", test_name,
                     $sampled(exp_head_value), $sampled(commit_value));
        end

    a_rob_bound: assert property (@(posedge clk) disable iff (rst)
        accept_count - commit_count <= ROB_DEPTH)
        else begin
            proto_errors++;
            $display("more than %0d instructions in flight", ROB_DEPTH);
        end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t r_type(input logic [9:0] op, input areg_t rd, rs1, rs2);
        return {op[9:3], rs2, rs1, op[2:0], rd, OPC_REG};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input areg_t rs1, rd);
        return {imm, rs1, 3'b000, rd, OPC_IMM};
    endfunction

    function automatic word_t model_result(input word_t w);
        word_t a;
        word_t b;
        a = arch_regs[w[19:15]];
        if (w[6:0] == OPC_IMM) return a + {{20{w[31]}}, w[31:20]};
        b = arch_regs[w[24:20]];
        case ({w[31:25], w[14:12]})
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_MUL:  return a * b;  // low word
            default: return 'x;
        endcase
    endfunction

    // program-order update of the reference registers
    task automatic expect_result(input word_t w);
        areg_t rd;
        word_t v;
        rd = w[11:7];
        v  = model_result(w);
        if (rd == '0) v = '0;
        else arch_regs[rd] = v;
        exp_rd_mem[sent_count[9:0]]    = rd;
        exp_value_mem[sent_count[9:0]] = v;
        sent_count++;
    endtask

    task automatic send(input word_t w);
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b1;
        inst       = w;
        expect_result(w);
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (commit_count != sent_count) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic word_t random_inst();
        areg_t       rd, rs1, rs2;
        logic [11:0] imm;
        rd  = areg_t'(rand_below(8));  // few regs so dependencies are common
        rs1 = areg_t'(rand_below(8));
        rs2 = areg_t'(rand_below(8));
        imm = 12'(rand_below(4096));
        case (rand_below(11))
            0, 1:    return i_type(imm, rs1, rd);
            2:       return r_type(OP_ADD, rd, rs1, rs2);
            3:       return r_type(OP_SUB, rd, rs1, rs2);
            4:       return r_type(OP_AND, rd, rs1, rs2);
            5:       return r_type(OP_OR, rd, rs1, rs2);
            6:       return r_type(OP_XOR, rd, rs1, rs2);
            7:       return r_type(OP_SLL, rd, rs1, rs2);
            8:       return r_type(OP_SRL, rd, rs1, rs2);
            default: return r_type(OP_MUL, rd, rs1, rs2);
        endcase
    endfunction

    task automatic print_summary();
        $display("summary: %0d rd errors, %0d value errors, %0d protocol errors, %0d/%0d committed",
                 rd_errors, value_errors, proto_errors, commit_count, sent_count);
    endtask

    initial begin
        seed       = 25610;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        test_name  = "reset";
        for (int i = 0; i < NUM_AREGS; i++) arch_regs[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (6) @(posedge clk);  // idle, nothing may commit
        #1;

        test_name = "addi";
        send(i_type(12'd100, 0, 1));
        send(i_type(12'hff9, 0, 2));
        send(i_type(12'h7ff, 0, 3));
        send(i_type(12'h800, 0, 4));
        send(i_type(12'd5, 1, 5));
        wait_drain();

        test_name = "alu_ops";
        send(r_type(OP_ADD, 6, 1, 2));
        send(r_type(OP_SUB, 7, 1, 2));
        send(r_type(OP_AND, 8, 2, 3));
        send(r_type(OP_OR, 9, 1, 4));
        send(r_type(OP_XOR, 10, 2, 3));
        send(r_type(OP_SLL, 11, 1, 5));
        send(r_type(OP_SRL, 12, 2, 5));
        wait_drain();

        test_name = "dep_chain";
        send(i_type(12'd1, 0, 13));
        for (int i = 0; i < 6; i++) send(r_type(OP_ADD, 13, 13, 13));
        send(r_type(OP_SUB, 14, 13, 1));
        send(r_type(OP_XOR, 14, 14, 13));
        wait_drain();

        test_name = "mul";
        send(r_type(OP_MUL, 15, 1, 2));
        send(r_type(OP_ADD, 16, 15, 3));
        send(r_type(OP_MUL, 17, 15, 15));
        send(r_type(OP_MUL, 18, 17, 4));
        send(r_type(OP_SUB, 19, 18, 16));
        wait_drain();

        test_name = "order";
        send(r_type(OP_MUL, 20, 3, 4));
        send(i_type(12'd5, 0, 21));
        send(i_type(12'd6, 0, 22));
        send(i_type(12'd1, 21, 23));
        wait_drain();

        test_name = "x0";
        send(i_type(12'd7, 1, 0));
        send(r_type(OP_ADD, 24, 0, 2));
        send(r_type(OP_MUL, 0, 1, 2));
        send(r_type(OP_OR, 25, 0, 0));
        send(r_type(OP_ADD, 0, 1, 1));
        send(i_type(12'd3, 0, 26));
        wait_drain();

        test_name = "random";
        for (int i = 0; i < N_RANDOM; i++) begin
            send(random_inst());
            if (rand_below(6) == 0) begin
                @(posedge clk);
                #1;
            end
        end
        wait_drain();
        repeat (10) @(posedge clk);  // no stray commits after drain

        print_summary();
        if (rd_errors + value_errors + proto_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // budget grows with every accepted instruction
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 40 * accept_count + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, core stopped accepting or committing", cycles);
        print_summary();
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/core_pkg.sv
logic/isa_pkg.sv
logic/rename_unit.sv
logic/phys_regfile.sv
logic/reservation_station.sv
logic/exec_units.sv
logic/reorder_buffer.sv
logic/ooo_core_top.sv
verification/tb_ooo_core.sv
